/* Makefile */
TOP = eye_tracker_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -Mdir obj_dir -f flist.f --top-module $(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* flist.f */
source/eye_pkg.sv
source/camera_input.sv
source/centroid_accum.sv
source/centroid_divider.sv
source/eye_regs.sv
source/eye_tracker_top.sv
tests/tb_clock.sv
tests/eye_tracker_tb.sv

/* source/camera_input.sv */
`timescale 1ns/1ps

module camera_input
    import eye_pkg::*;
(
    input  logic                   cclk,
    input  logic                   reset,
    input  cam_bus_t               cam,
    input  logic [PIXEL_WIDTH-1:0] threshold,
    output pixel_pair_t            pixel
);

    logic                   fval_q;
    logic                   lval_q;
    logic [COORD_WIDTH-1:0] col_cnt;
    logic [COORD_WIDTH-1:0] row_cnt;
    logic [PIXEL_WIDTH-1:0] thr_q;

    logic                   frame_start;
    logic                   frame_end;
    logic                   line_start;
    logic                   line_end;
    logic                   pair_valid;
    logic [COORD_WIDTH-1:0] col_cur;
    logic [COORD_WIDTH-1:0] row_cur;
    logic [PIXEL_WIDTH-1:0] thr_cur;

    // Strobe edges
    assign frame_start = cam.fval & ~fval_q;
    assign frame_end   = ~cam.fval & fval_q;
    assign line_start  = cam.lval & ~lval_q;
    assign line_end    = ~cam.lval & lval_q;
    assign pair_valid  = cam.fval & cam.lval & cam.dval;

    // Position of this pair, restarts folded in
    assign col_cur = line_start ? '0 : col_cnt;
    assign row_cur = frame_start ? '0 : row_cnt;
    // Threshold is frozen for the whole frame
    assign thr_cur = frame_start ? threshold : thr_q;

    always_ff @(posedge cclk) begin
        if (reset) begin
            fval_q  <= 1'b0;
            lval_q  <= 1'b0;
            col_cnt <= '0;
            row_cnt <= '0;
            thr_q   <= '0;
            pixel   <= '0;
        end else begin
            fval_q  <= cam.fval;
            lval_q  <= cam.lval;
            col_cnt <= pair_valid ? col_cur + 1'b1 : col_cur;
            row_cnt <= line_end ? row_cur + 1'b1 : row_cur;
            thr_q   <= thr_cur;

            pixel.frame_start <= frame_start;
            pixel.frame_end   <= frame_end;
            pixel.valid       <= pair_valid;
            pixel.col         <= col_cur;
            pixel.row         <= row_cur;
            pixel.dark_l      <= pair_valid & (cam.data_l < thr_cur);
            pixel.dark_r      <= pair_valid & (cam.data_r < thr_cur);
        end
    end

endmodule

/* source/centroid_accum.sv */
`timescale 1ns/1ps

module centroid_accum
    import eye_pkg::*;
(
    input  logic           cclk,
    input  logic           reset,
    input  logic           enable,
    input  pixel_pair_t    pixel,
    output centroid_sums_t sums,
    output logic           sums_valid
);

    logic                    en_q;
    logic [SUM_S_WIDTH-1:0]  acc_s;
    logic [SUM_XY_WIDTH-1:0] acc_sx;
    logic [SUM_XY_WIDTH-1:0] acc_sy;

    logic [1:0]              n_dark;
    logic [SUM_XY_WIDTH-1:0] add_x;
    logic [SUM_XY_WIDTH-1:0] add_y;
    logic [SUM_S_WIDTH-1:0]  base_s;
    logic [SUM_XY_WIDTH-1:0] base_sx;
    logic [SUM_XY_WIDTH-1:0] base_sy;

    // --------------------------------------------------
    // Contribution of one pair
    // --------------------------------------------------
    always_comb begin
        n_dark = 2'd0;
        add_x  = '0;
        add_y  = '0;
        if (pixel.valid && pixel.dark_l) begin
            n_dark = n_dark + 2'd1;
            // Left tap sits at even x
            add_x  = add_x + SUM_XY_WIDTH'({pixel.col, 1'b0});
            add_y  = add_y + SUM_XY_WIDTH'(pixel.row);
        end
        if (pixel.valid && pixel.dark_r) begin
            n_dark = n_dark + 2'd1;
            add_x  = add_x + SUM_XY_WIDTH'({pixel.col, 1'b1});
            add_y  = add_y + SUM_XY_WIDTH'(pixel.row);
        end
    end

    // Fresh totals at the first cycle of a frame
    assign base_s  = pixel.frame_start ? '0 : acc_s;
    assign base_sx = pixel.frame_start ? '0 : acc_sx;
    assign base_sy = pixel.frame_start ? '0 : acc_sy;

    always_ff @(posedge cclk) begin
        if (reset) begin
            en_q       <= 1'b0;
            acc_s      <= '0;
            acc_sx     <= '0;
            acc_sy     <= '0;
            sums_valid <= 1'b0;
        end else begin
            if (pixel.frame_start) begin
                en_q <= enable;
            end
            acc_s      <= base_s + SUM_S_WIDTH'(n_dark);
            acc_sx     <= base_sx + add_x;
            acc_sy     <= base_sy + add_y;
            sums_valid <= pixel.frame_end & en_q;
        end
    end

    // Frame totals handed to the divider
    always_ff @(posedge cclk) begin
        if (pixel.frame_end) begin
            sums <= '{sum_s: acc_s, sum_sx: acc_sx, sum_sy: acc_sy};
        end
    end

endmodule

/* source/centroid_divider.sv */
`timescale 1ns/1ps

module centroid_divider
    import eye_pkg::*;
(
    input  logic             cclk,
    input  logic             reset,
    input  centroid_sums_t   sums,
    input  logic             sums_valid,
    output logic             busy,
    output centroid_result_t result,
    output logic             result_valid
);

    // Partial remainder and dividend that turns into the quotient
    typedef struct packed {
        logic [SUM_S_WIDTH-1:0]  rem;
        logic [SUM_XY_WIDTH-1:0] quo;
    } div_state_t;

    logic [DIV_COUNT_WIDTH-1:0] count;
    centroid_sums_t             sums_q;
    div_state_t                 div_x;
    div_state_t                 div_y;
    div_state_t                 next_x;
    div_state_t                 next_y;
    logic                       start;
    logic                       sum_zero;
    logic                       last_step;

    // One restoring shift-subtract step
    function automatic div_state_t div_step(input div_state_t cur,
                                            input logic [SUM_S_WIDTH-1:0] den);
        div_state_t           nxt;
        logic [SUM_S_WIDTH:0] trial;
        logic                 q_bit;
        trial = {cur.rem, cur.quo[SUM_XY_WIDTH-1]};
        q_bit = (trial >= {1'b0, den});
        if (q_bit) begin
            trial = trial - {1'b0, den};
        end
        nxt.rem = trial[SUM_S_WIDTH-1:0];
        nxt.quo = {cur.quo[SUM_XY_WIDTH-2:0], q_bit};
        return nxt;
    endfunction

    assign start     = sums_valid & ~busy;
    assign sum_zero  = (sums.sum_s == '0);
    assign last_step = (count == DIV_COUNT_WIDTH'(SUM_XY_WIDTH - 1));

    always_comb begin
        next_x = div_step(div_x, sums_q.sum_s);
        next_y = div_step(div_y, sums_q.sum_s);
    end

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    always_ff @(posedge cclk) begin
        if (reset) begin
            busy         <= 1'b0;
            count        <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (start) begin
                count        <= '0;
                busy         <= ~sum_zero;
                // Empty frame needs no division
                result_valid <= sum_zero;
            end else if (busy) begin
                count <= count + 1'b1;
                if (last_step) begin
                    busy         <= 1'b0;
                    result_valid <= 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------
    always_ff @(posedge cclk) begin
        if (start) begin
            sums_q <= sums;
            div_x  <= '{rem: '0, quo: sums.sum_sx};
            div_y  <= '{rem: '0, quo: sums.sum_sy};
            if (sum_zero) begin
                result <= '{sums: sums, center_x: '0, center_y: '0};
            end
        end else if (busy) begin
            div_x <= next_x;
            div_y <= next_y;
            if (last_step) begin
                result <= '{sums:     sums_q,
                            center_x: next_x.quo[COORD_WIDTH-1:0],
                            center_y: next_y.quo[COORD_WIDTH-1:0]};
            end
        end
    end

endmodule

/* source/eye_pkg.sv */
package eye_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int PIXEL_WIDTH     = 8;
    localparam int COORD_WIDTH     = 10;
    localparam int SUM_S_WIDTH     = 20;
    localparam int SUM_XY_WIDTH    = 28;
    localparam int APB_ADDR_WIDTH  = 8;
    localparam int APB_DATA_WIDTH  = 32;
    localparam int DIV_COUNT_WIDTH = $clog2(SUM_XY_WIDTH);

    // --------------------------------------------------
    // Register map
    // --------------------------------------------------
    localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL        = 8'h00;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_THRESHOLD   = 8'h04;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS      = 8'h08;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_SUM_S       = 8'h0C;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_SUM_SX      = 8'h10;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_SUM_SY      = 8'h14;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_CENTER      = 8'h18;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_FRAME_COUNT = 8'h1C;

    // Camera link taps and strobes
    typedef struct packed {
        logic                   fval;
        logic                   lval;
        logic                   dval;
        logic [PIXEL_WIDTH-1:0] data_l;
        logic [PIXEL_WIDTH-1:0] data_r;
    } cam_bus_t;

    typedef struct packed {
        logic                   frame_start;
        logic                   frame_end;
        logic                   valid;
        logic [COORD_WIDTH-1:0] col;
        logic [COORD_WIDTH-1:0] row;
        logic                   dark_l;
        logic                   dark_r;
    } pixel_pair_t;

    typedef struct packed {
        logic [SUM_S_WIDTH-1:0]  sum_s;
        logic [SUM_XY_WIDTH-1:0] sum_sx;
        logic [SUM_XY_WIDTH-1:0] sum_sy;
    } centroid_sums_t;

    typedef struct packed {
        centroid_sums_t         sums;
        logic [COORD_WIDTH-1:0] center_x;
        logic [COORD_WIDTH-1:0] center_y;
    } centroid_result_t;

    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [APB_ADDR_WIDTH-1:0] paddr;
        logic [APB_DATA_WIDTH-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_WIDTH-1:0] prdata;
        logic                      pready;
        logic                      pslverr;
    } apb_rsp_t;

endpackage

/* source/eye_regs.sv */
`timescale 1ns/1ps

module eye_regs
    import eye_pkg::*;
(
    input  logic                   cclk,
    input  logic                   reset,
    input  apb_req_t               apb_req,
    input  centroid_result_t       result,
    input  logic                   result_valid,
    output apb_rsp_t               apb_rsp,
    output logic [PIXEL_WIDTH-1:0] threshold,
    output logic                   enable
);

    localparam int PAD_WIDTH = 16 - COORD_WIDTH;

    centroid_result_t          res_q;
    logic                      result_ready;
    logic [APB_DATA_WIDTH-1:0] frame_count;

    logic                      access;
    logic                      addr_ok;
    logic                      read_only;
    logic                      wr_en;
    logic                      status_rd;
    logic [APB_DATA_WIDTH-1:0] rdata;

    // --------------------------------------------------
    // Address decode and read mux
    // --------------------------------------------------
    always_comb begin
        rdata     = '0;
        addr_ok   = 1'b1;
        read_only = 1'b1;
        case (apb_req.paddr)
            REG_CTRL: begin
                rdata     = APB_DATA_WIDTH'(enable);
                read_only = 1'b0;
            end
            REG_THRESHOLD: begin
                rdata     = APB_DATA_WIDTH'(threshold);
                read_only = 1'b0;
            end
            REG_STATUS:      rdata = APB_DATA_WIDTH'(result_ready);
            REG_SUM_S:       rdata = APB_DATA_WIDTH'(res_q.sums.sum_s);
            REG_SUM_SX:      rdata = APB_DATA_WIDTH'(res_q.sums.sum_sx);
            REG_SUM_SY:      rdata = APB_DATA_WIDTH'(res_q.sums.sum_sy);
            REG_CENTER: begin
                rdata = {{PAD_WIDTH{1'b0}}, res_q.center_y,
                         {PAD_WIDTH{1'b0}}, res_q.center_x};
            end
            REG_FRAME_COUNT: rdata = frame_count;
            default:         addr_ok = 1'b0;
        endcase
    end

    // No wait states, so every access phase completes
    assign access    = apb_req.psel & apb_req.penable;
    assign wr_en     = access & apb_req.pwrite & addr_ok & ~read_only;
    assign status_rd = access & ~apb_req.pwrite & (apb_req.paddr == REG_STATUS);

    assign apb_rsp = '{prdata:  rdata,
                       pready:  1'b1,
                       pslverr: access & (~addr_ok | (apb_req.pwrite & read_only))};

    always_ff @(posedge cclk) begin
        if (reset) begin
            enable       <= 1'b0;
            threshold    <= 8'h40;
            result_ready <= 1'b0;
            frame_count  <= '0;
            res_q        <= '0;
        end else begin
            if (wr_en && apb_req.paddr == REG_CTRL) begin
                enable <= apb_req.pwdata[0];
            end
            if (wr_en && apb_req.paddr == REG_THRESHOLD) begin
                threshold <= apb_req.pwdata[PIXEL_WIDTH-1:0];
            end
            // A new result wins over a clearing read
            if (result_valid) begin
                result_ready <= 1'b1;
                res_q        <= result;
                frame_count  <= frame_count + 1'b1;
            end else if (status_rd) begin
                result_ready <= 1'b0;
            end
        end
    end

endmodule

/* source/eye_tracker_top.sv */
`timescale 1ns/1ps

module eye_tracker_top
    import eye_pkg::*;
(
    input  logic     cclk,
    input  logic     reset,
    input  cam_bus_t cam,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    logic [PIXEL_WIDTH-1:0] threshold;
    logic                   enable;
    pixel_pair_t            pixel;
    centroid_sums_t         sums;
    logic                   sums_valid;
    logic                   busy;
    centroid_result_t       result;
    logic                   result_valid;

    // --------------------------------------------------
    // Pixel pipeline
    // --------------------------------------------------
    camera_input m_camera_input (
        .cclk      (cclk),
        .reset     (reset),
        .cam       (cam),
        .threshold (threshold),
        .pixel     (pixel)
    );

    centroid_accum m_centroid_accum (
        .cclk       (cclk),
        .reset      (reset),
        .enable     (enable),
        .pixel      (pixel),
        .sums       (sums),
        .sums_valid (sums_valid)
    );

    centroid_divider m_centroid_divider (
        .cclk         (cclk),
        .reset        (reset),
        .sums         (sums),
        .sums_valid   (sums_valid),
        .busy         (busy),
        .result       (result),
        .result_valid (result_valid)
    );

    // Host side
    eye_regs m_eye_regs (
        .cclk         (cclk),
        .reset        (reset),
        .apb_req      (apb_req),
        .result       (result),
        .result_valid (result_valid),
        .apb_rsp      (apb_rsp),
        .threshold    (threshold),
        .enable       (enable)
    );

endmodule

/* tests/eye_tracker_tb.sv */
`timescale 1ns/1ps

module eye_tracker_tb
    import eye_pkg::*;
();

    localparam int MIN_LINES     = 8;
    localparam int MAX_LINES     = 24;
    localparam int MIN_PAIRS     = 4;
    localparam int MAX_PAIRS     = 16;
    localparam int MAX_GAP       = 2;
    localparam int FRONT_PORCH   = 2;
    localparam int LINE_BLANK    = 3;
    localparam int IDLE_CYCLES   = 40;
    localparam int RANDOM_FRAMES = 20;
    localparam int TOTAL_FRAMES  = RANDOM_FRAMES + 4;
    localparam int FRAME_CYCLES  = FRONT_PORCH + 1 + IDLE_CYCLES
                                 + MAX_LINES * (MAX_PAIRS * (MAX_GAP + 1) + LINE_BLANK);
    localparam int CYCLE_LIMIT   = 20 * TOTAL_FRAMES * FRAME_CYCLES;
    localparam int POLL_LIMIT    = 50;
    localparam logic [31:0] SEED       = 32'hd030_bb75;
    localparam logic [31:0] COORD_MASK = (32'd1 << COORD_WIDTH) - 32'd1;
    localparam logic [APB_ADDR_WIDTH-1:0] BAD_ADDR = 8'h40;

    logic        cclk;
    logic        reset;
    cam_bus_t    cam;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    int          cycle_count = 0;
    logic [31:0] exp_s;
    logic [31:0] exp_sx;
    logic [31:0] exp_sy;
    logic [31:0] exp_frames;

    tb_clock clock_gen (.cclk(cclk), .reset(reset));

    eye_tracker_top dut0 (
        .cclk    (cclk),
        .reset   (reset),
        .cam     (cam),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    task automatic stop_with_error(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_error($sformatf("[FAIL] %s: expected 0x%08h, got 0x%08h",
                                      name, expected, actual));
        end
    endtask

    always @(posedge cclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            stop_with_error("Timeout: the run went past its cycle limit");
        end
    end

    // --------------------------------------------------
    // APB host
    // --------------------------------------------------
    task automatic apb_access(input logic write, input logic [APB_ADDR_WIDTH-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge cclk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge cclk);
        apb_req.penable <= 1'b1;
        // Response sampled mid access phase
        @(negedge cclk);
        check_value("pready", 32'd1, 32'(apb_rsp.pready));
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge cclk);
        apb_req <= '0;
    endtask

    task automatic reg_write(input logic [APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        apb_access(1'b1, addr, data, unused, err);
        check_value($sformatf("pslverr write 0x%02h", addr), 32'd0, 32'(err));
    endtask

    task automatic reg_read(input logic [APB_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'd0, data, err);
        check_value($sformatf("pslverr read 0x%02h", addr), 32'd0, 32'(err));
    endtask

    // --------------------------------------------------
    // Camera frames and reference model
    // --------------------------------------------------
    task automatic drive_cam(input logic fval, input logic lval, input logic dval,
                             input logic [PIXEL_WIDTH-1:0] data_l,
                             input logic [PIXEL_WIDTH-1:0] data_r);
        @(posedge cclk);
        cam <= '{fval: fval, lval: lval, dval: dval, data_l: data_l, data_r: data_r};
    endtask

    task automatic drive_frame(input logic [PIXEL_WIDTH-1:0] thr);
        int                     lines;
        int                     pairs;
        int                     gap;
        logic [PIXEL_WIDTH-1:0] data_l;
        logic [PIXEL_WIDTH-1:0] data_r;
        lines  = MIN_LINES + int'($urandom % (MAX_LINES - MIN_LINES + 1));
        pairs  = MIN_PAIRS + int'($urandom % (MAX_PAIRS - MIN_PAIRS + 1));
        exp_s  = 32'd0;
        exp_sx = 32'd0;
        exp_sy = 32'd0;
        repeat (FRONT_PORCH + 1) drive_cam(1'b1, 1'b0, 1'b0, '0, '0);
        for (int row = 0; row < lines; row++) begin
            for (int col = 0; col < pairs; col++) begin
                gap = int'($urandom % (MAX_GAP + 1));
                // Stalls with dval low inside the line
                repeat (gap) begin
                    drive_cam(1'b1, 1'b1, 1'b0, PIXEL_WIDTH'($urandom), PIXEL_WIDTH'($urandom));
                end
                data_l = PIXEL_WIDTH'($urandom);
                data_r = PIXEL_WIDTH'($urandom);
                drive_cam(1'b1, 1'b1, 1'b1, data_l, data_r);
                if (data_l < thr) begin
                    exp_s  = exp_s + 32'd1;
                    exp_sx = exp_sx + 32'(2 * col);
                    exp_sy = exp_sy + 32'(row);
                end
                if (data_r < thr) begin
                    exp_s  = exp_s + 32'd1;
                    exp_sx = exp_sx + 32'(2 * col + 1);
                    exp_sy = exp_sy + 32'(row);
                end
            end
            repeat (LINE_BLANK) drive_cam(1'b1, 1'b0, 1'b0, '0, '0);
        end
        repeat (IDLE_CYCLES) drive_cam(1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic check_result();
        logic [31:0] value;
        logic [31:0] cx;
        logic [31:0] cy;
        int          polls;
        polls = 0;
        value = 32'd0;
        while (value[0] !== 1'b1) begin
            if (polls == POLL_LIMIT) begin
                stop_with_error("STATUS never showed a result after the frame ended");
            end
            reg_read(REG_STATUS, value);
            polls++;
        end
        cx = 32'd0;
        cy = 32'd0;
        if (exp_s != 32'd0) begin
            cx = (exp_sx / exp_s) & COORD_MASK;
            cy = (exp_sy / exp_s) & COORD_MASK;
        end
        exp_frames = exp_frames + 32'd1;
        reg_read(REG_SUM_S, value);
        check_value("SUM_S", exp_s, value);
        reg_read(REG_SUM_SX, value);
        check_value("SUM_SX", exp_sx, value);
        reg_read(REG_SUM_SY, value);
        check_value("SUM_SY", exp_sy, value);
        reg_read(REG_CENTER, value);
        check_value("CENTER", (cy << 16) | cx, value);
        reg_read(REG_FRAME_COUNT, value);
        check_value("FRAME_COUNT", exp_frames, value);
        // Status was cleared by the read that saw it set
        reg_read(REG_STATUS, value);
        check_value("STATUS", 32'd0, value);
    endtask

    initial begin
        logic [31:0]            value;
        logic                   err;
        logic [PIXEL_WIDTH-1:0] thr;
        logic [PIXEL_WIDTH-1:0] new_thr;
        cam        = '0;
        apb_req    = '0;
        exp_frames = 32'd0;
        void'($urandom(SEED));
        while (reset !== 1'b0) begin
            @(posedge cclk);
        end

        // Reset values
        reg_read(REG_CTRL, value);
        check_value("CTRL", 32'd0, value);
        reg_read(REG_THRESHOLD, value);
        check_value("THRESHOLD", 32'h40, value);
        reg_read(REG_STATUS, value);
        check_value("STATUS", 32'd0, value);
        reg_read(REG_FRAME_COUNT, value);
        check_value("FRAME_COUNT", 32'd0, value);

        // Read back and bus errors
        reg_write(REG_CTRL, 32'd1);
        reg_read(REG_CTRL, value);
        check_value("CTRL", 32'd1, value);
        thr = PIXEL_WIDTH'($urandom);
        reg_write(REG_THRESHOLD, 32'hffff_ff00 | 32'(thr));
        reg_read(REG_THRESHOLD, value);
        check_value("THRESHOLD", 32'(thr), value);
        apb_access(1'b1, REG_SUM_S, 32'h1234, value, err);
        check_value("pslverr write SUM_S", 32'd1, 32'(err));
        reg_read(REG_SUM_S, value);
        check_value("SUM_S", 32'd0, value);
        apb_access(1'b0, BAD_ADDR, 32'd0, value, err);
        check_value("pslverr read 0x40", 32'd1, 32'(err));
        apb_access(1'b1, BAD_ADDR, 32'd5, value, err);
        check_value("pslverr write 0x40", 32'd1, 32'(err));

        // Random frames
        for (int i = 0; i < RANDOM_FRAMES; i++) begin
            thr = PIXEL_WIDTH'($urandom);
            reg_write(REG_THRESHOLD, 32'(thr));
            drive_frame(thr);
            check_result();
        end

        // Threshold change inside a frame
        thr     = PIXEL_WIDTH'($urandom);
        new_thr = thr ^ 8'h80;
        reg_write(REG_THRESHOLD, 32'(thr));
        fork
            drive_frame(thr);
            begin
                repeat (20) @(posedge cclk);
                reg_write(REG_THRESHOLD, 32'(new_thr));
            end
        join
        check_result();
        drive_frame(new_thr);
        check_result();

        // Disabled frame
        reg_write(REG_CTRL, 32'd0);
        drive_frame(new_thr);
        repeat (2 * SUM_XY_WIDTH) @(posedge cclk);
        reg_read(REG_STATUS, value);
        check_value("STATUS", 32'd0, value);
        reg_read(REG_FRAME_COUNT, value);
        check_value("FRAME_COUNT", exp_frames, value);

        // No dark pixels at all
        reg_write(REG_CTRL, 32'd1);
        reg_write(REG_THRESHOLD, 32'd0);
        drive_frame(8'd0);
        check_result();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic cclk,
    output logic reset
);

    localparam int PERIOD = 40;

    initial begin
        cclk = 1'b0;
        forever begin
            #(PERIOD / 2) cclk = ~cclk;
        end
    end

    // Reset held over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge cclk);
        reset <= 1'b0;
    end

endmodule
